// ==== common/cpuPkg.sv ====
package cpuPkg;

	typedef logic [15:0] word_t;   // data and address word
	typedef logic [3:0] regAddr_t; // one of sixteen registers
	typedef logic [3:0] opcode_t;  // instr[15:12]
	typedef logic [2:0] aluOp_t;
	typedef logic [2:0] cond_t;    // branch condition, instr[11:9]
	typedef logic [1:0] fwdSel_t;  // operand source in execute

	localparam opcode_t opAdd = 4'h0;
	localparam opcode_t opSub = 4'h1;
	localparam opcode_t opXor = 4'h2;
	localparam opcode_t opSll = 4'h4;
	localparam opcode_t opSra = 4'h5;
	localparam opcode_t opLw  = 4'h8;
	localparam opcode_t opSw  = 4'h9;
	localparam opcode_t opLlb = 4'hA;
	localparam opcode_t opLhb = 4'hB;
	localparam opcode_t opB   = 4'hC;
	localparam opcode_t opHlt = 4'hF;

	localparam aluOp_t aluAdd = 3'd0;
	localparam aluOp_t aluSub = 3'd1;
	localparam aluOp_t aluXor = 3'd2;
	localparam aluOp_t aluSll = 3'd3;
	localparam aluOp_t aluSra = 3'd4;

	localparam cond_t condNe = 3'd0; // z clear
	localparam cond_t condEq = 3'd1; // z set
	localparam cond_t condGt = 3'd2; // z and n clear
	localparam cond_t condLt = 3'd3; // n set
	localparam cond_t condGe = 3'd4; // n clear
	localparam cond_t condLe = 3'd5; // z or n set
	localparam cond_t condOv = 3'd6; // v set
	localparam cond_t condAl = 3'd7; // unconditional

	localparam fwdSel_t fwdNone = 2'd0; // value read in decode
	localparam fwdSel_t fwdWb   = 2'd1; // writeback value
	localparam fwdSel_t fwdMem  = 2'd2; // memory stage value

	localparam word_t resetPc = 16'h0000;
	localparam word_t wordMax = 16'h7FFF; // saturation limits
	localparam word_t wordMin = 16'h8000;

	typedef struct packed {
		aluOp_t aluOp;
		logic aluSrc;   // second operand is the immediate
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic llb;
		logic lhb;
		logic branch;
		cond_t cond;
		logic halt;
		logic setZ;     // loads z flag
		logic setNv;    // loads n and v flags
	} ctrl_t;

	typedef struct packed {
		logic valid;
		word_t instr;
		word_t pcPlus2;
	} ifId_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		word_t srcData1;
		word_t srcData2;
		regAddr_t src1;
		regAddr_t src2;
		regAddr_t dst;
		word_t imm;
		word_t pcPlus2;
	} idEx_t;

	typedef struct packed {
		logic valid;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic halt;
		word_t result;    // alu or byte load result, also the address
		word_t storeData;
		regAddr_t dst;
	} exMem_t;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic halt;
		word_t wbData;
		regAddr_t dst;
	} memWb_t;

endpackage

// ==== cpu/alu.sv ====
`timescale 1ns/1ps

module alu (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluOp_t op,
	output cpuPkg::word_t result,
	output logic z,
	output logic n,
	output logic v
);
	import cpuPkg::*;

	word_t sum, diff, satLimit;
	logic addOvf, subOvf;

	assign sum = a + b;
	assign diff = a - b;
	assign addOvf = (a[15] == b[15]) && (sum[15] != a[15]); // same signs, flipped result
	assign subOvf = (a[15] != b[15]) && (diff[15] != a[15]);
	assign satLimit = a[15] ? wordMin : wordMax; // overflow direction follows a

	always_comb begin
		v = 1'b0;
		case (op)
			aluAdd: begin
				v = addOvf;
				result = addOvf ? satLimit : sum;
			end
			aluSub: begin
				v = subOvf;
				result = subOvf ? satLimit : diff;
			end
			aluXor: result = a ^ b;
			aluSll: result = a << b[3:0];
			aluSra: result = $signed(a) >>> b[3:0]; // sign fill
			default: result = sum;
		endcase
	end

	assign z = (result == 16'd0);
	assign n = result[15];

endmodule

// ==== cpu/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input cpuPkg::word_t instr,
	output cpuPkg::ctrl_t ctrl,
	output cpuPkg::regAddr_t srcReg1,
	output cpuPkg::regAddr_t srcReg2,
	output cpuPkg::regAddr_t dstReg,
	output cpuPkg::word_t imm
);
	import cpuPkg::*;

	opcode_t opcode;
	regAddr_t rd, rs, rt;

	assign opcode = instr[15:12];
	assign rd = instr[11:8];
	assign rs = instr[7:4];
	assign rt = instr[3:0]; // shift amount or offset for some ops

	always_comb begin
		ctrl = '0; // unknown opcodes fall through as no-ops
		srcReg1 = '0;
		srcReg2 = '0;
		dstReg = '0;
		imm = '0;
		case (opcode)
			opAdd, opSub: begin
				ctrl.aluOp = (opcode == opSub) ? aluSub : aluAdd;
				ctrl.regWrite = 1'b1;
				ctrl.setZ = 1'b1;
				ctrl.setNv = 1'b1;
				srcReg1 = rs;
				srcReg2 = rt;
				dstReg = rd;
			end
			opXor: begin
				ctrl.aluOp = aluXor;
				ctrl.regWrite = 1'b1;
				ctrl.setZ = 1'b1; // z only
				srcReg1 = rs;
				srcReg2 = rt;
				dstReg = rd;
			end
			opSll, opSra: begin
				ctrl.aluOp = (opcode == opSra) ? aluSra : aluSll;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.setZ = 1'b1;
				srcReg1 = rs;
				dstReg = rd;
				imm = {12'd0, rt}; // 4-bit shift amount
			end
			opLw, opSw: begin
				ctrl.aluOp = aluAdd;
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = (opcode == opLw);
				ctrl.memWrite = (opcode == opSw);
				ctrl.regWrite = (opcode == opLw);
				srcReg1 = rs; // base
				srcReg2 = (opcode == opSw) ? rd : 4'd0; // store data
				dstReg = (opcode == opLw) ? rd : 4'd0;
				imm = {{11{rt[3]}}, rt, 1'b0}; // word offset in bytes
			end
			opLlb, opLhb: begin
				ctrl.llb = (opcode == opLlb);
				ctrl.lhb = (opcode == opLhb);
				ctrl.regWrite = 1'b1;
				srcReg1 = rd; // old value for the untouched byte
				dstReg = rd;
				imm = {8'd0, instr[7:0]};
			end
			opB: begin
				ctrl.branch = 1'b1;
				ctrl.cond = instr[11:9];
				imm = {{6{instr[8]}}, instr[8:0], 1'b0};
			end
			opHlt: begin
				ctrl.halt = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== cpu/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic rstN,
	input cpuPkg::regAddr_t srcReg1,
	input cpuPkg::regAddr_t srcReg2,
	input cpuPkg::regAddr_t dstReg,
	input logic writeEn,
	input cpuPkg::word_t dstData,
	output cpuPkg::word_t srcData1,
	output cpuPkg::word_t srcData2
);
	import cpuPkg::*;

	word_t regs [16];
	logic writeLive;

	assign writeLive = writeEn && (dstReg != 4'd0); // r0 is hardwired

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (writeLive) begin
			regs[dstReg] <= dstData;
		end
	end

	// same-cycle write is visible to decode
	assign srcData1 = (srcReg1 == 4'd0) ? '0 :
		(writeLive && dstReg == srcReg1) ? dstData : regs[srcReg1];
	assign srcData2 = (srcReg2 == 4'd0) ? '0 :
		(writeLive && dstReg == srcReg2) ? dstData : regs[srcReg2];

endmodule

// ==== cpu/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
	input cpuPkg::regAddr_t idSrc1,
	input cpuPkg::regAddr_t idSrc2,
	input cpuPkg::regAddr_t exSrc1,
	input cpuPkg::regAddr_t exSrc2,
	input cpuPkg::regAddr_t exDst,
	input logic exMemRead,
	input cpuPkg::regAddr_t memDst,
	input logic memRegWrite,
	input cpuPkg::regAddr_t wbDst,
	input logic wbRegWrite,
	input logic branchTaken,
	input logic memBusy,
	output cpuPkg::fwdSel_t fwdA,
	output cpuPkg::fwdSel_t fwdB,
	output logic stall,
	output logic flush,
	output logic pipeEn
);
	import cpuPkg::*;

	// newest producer wins, r0 never forwards
	function automatic fwdSel_t pickFwd(regAddr_t src, regAddr_t mDst, logic mWe,
			regAddr_t wDst, logic wWe);
		fwdSel_t sel;
		sel = fwdNone;
		if (src != 4'd0) begin
			if (mWe && mDst == src) begin
				sel = fwdMem;
			end else if (wWe && wDst == src) begin
				sel = fwdWb;
			end
		end
		return sel;
	endfunction

	assign fwdA = pickFwd(exSrc1, memDst, memRegWrite, wbDst, wbRegWrite);
	assign fwdB = pickFwd(exSrc2, memDst, memRegWrite, wbDst, wbRegWrite);

	// load result not ready until after memory, one bubble
	assign stall = exMemRead && (exDst != 4'd0) &&
		((exDst == idSrc1) || (exDst == idSrc2));

	assign flush = branchTaken; // squash IF/ID and ID/EX
	assign pipeEn = !memBusy;

endmodule

// ==== rtl/dataMemPort.sv ====
`timescale 1ns/1ps

module dataMemPort (
	input logic clk,
	input logic rstN,
	input logic access,
	input logic write,
	input cpuPkg::word_t addr,
	input cpuPkg::word_t wdata,
	output cpuPkg::word_t rdata,
	output logic busy,
	output logic dmemReq,
	output logic dmemWrite,
	output cpuPkg::word_t dmemAddr,
	output cpuPkg::word_t dmemWdata,
	input logic dmemAck,
	input cpuPkg::word_t dmemRdata
);
	import cpuPkg::*;

	typedef enum logic [1:0] {
		idle,
		waitAck,
		waitRelease,
		done
	} state_t;

	state_t state;
	logic start;

	assign start = (state == idle) && access;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (access) state <= waitAck;
				waitAck: if (dmemAck) state <= waitRelease; // drop req
				waitRelease: if (!dmemAck) state <= done;   // handshake closed
				default: state <= idle; // done lasts one cycle
			endcase
		end
	end

	// request fields held stable for the whole handshake
	always_ff @(posedge clk) begin
		if (start) begin
			dmemAddr <= addr;
			dmemWdata <= wdata;
			dmemWrite <= write;
		end
	end

	always_ff @(posedge clk) begin
		if (state == waitAck && dmemAck && !dmemWrite) begin
			rdata <= dmemRdata; // first ack cycle only
		end
	end

	assign dmemReq = (state == waitAck);

	// free in done so the memory stage moves on exactly once
	assign busy = (state == idle) ? access : (state != done);

endmodule

// ==== cpu/cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input logic clk,
	input logic rstN,
	output cpuPkg::word_t pc,
	input cpuPkg::word_t imemData,
	output logic dmemReq,
	output logic dmemWrite,
	output cpuPkg::word_t dmemAddr,
	output cpuPkg::word_t dmemWdata,
	input logic dmemAck,
	input cpuPkg::word_t dmemRdata,
	output logic hlt
);
	import cpuPkg::*;

	ifId_t ifId, ifIdNext;
	idEx_t idEx, idExNext;
	exMem_t exMem, exMemNext;
	memWb_t memWb, memWbNext;

	ctrl_t idCtrl;
	regAddr_t idSrc1, idSrc2, idDst;
	word_t idImm, idData1, idData2;
	word_t pcPlus2, branchTarget;
	fwdSel_t fwdA, fwdB;
	logic stall, flush, pipeEn, memBusy;
	logic zFlag, nFlag, vFlag;
	word_t opA, opB, aluB, aluResult, exResult;
	logic aluZ, aluN, aluV, condMet, branchTaken;
	word_t portRdata, memValue;
	logic idHalt, fetchStop, fetchStopped, haltSeen;

	assign pcPlus2 = pc + 16'd2;
	assign idHalt = ifId.valid & idCtrl.halt; // hlt sitting in decode
	assign fetchStop = fetchStopped | idHalt;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
		end else if (pipeEn) begin
			if (flush) begin
				pc <= branchTarget; // taken branch from execute
			end else if (!stall && !fetchStop) begin
				pc <= pcPlus2;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			fetchStopped <= 1'b0;
		end else if (pipeEn && idHalt && !flush) begin
			fetchStopped <= 1'b1; // sticky, nothing after hlt is fetched
		end
	end

	always_comb begin
		if (flush || fetchStop) begin
			ifIdNext = '0; // squash
		end else if (stall) begin
			ifIdNext = ifId;
		end else begin
			ifIdNext.valid = 1'b1;
			ifIdNext.instr = imemData;
			ifIdNext.pcPlus2 = pcPlus2;
		end
	end

	controlUnit iCtrl (
		.instr(ifId.instr),
		.ctrl(idCtrl),
		.srcReg1(idSrc1),
		.srcReg2(idSrc2),
		.dstReg(idDst),
		.imm(idImm)
	);

	registerFile iRegFile (
		.clk(clk),
		.rstN(rstN),
		.srcReg1(idSrc1),
		.srcReg2(idSrc2),
		.dstReg(memWb.dst),
		.writeEn(memWb.valid & memWb.regWrite),
		.dstData(memWb.wbData),
		.srcData1(idData1),
		.srcData2(idData2)
	);

	always_comb begin
		idExNext.valid = ifId.valid;
		idExNext.ctrl = idCtrl;
		idExNext.srcData1 = idData1;
		idExNext.srcData2 = idData2;
		idExNext.src1 = idSrc1;
		idExNext.src2 = idSrc2;
		idExNext.dst = idDst;
		idExNext.imm = idImm;
		idExNext.pcPlus2 = ifId.pcPlus2;
		if (flush || stall) begin
			idExNext = '0; // bubble into execute
		end
	end

	always_comb begin
		case (fwdA)
			fwdMem: opA = memValue;
			fwdWb: opA = memWb.wbData;
			default: opA = idEx.srcData1;
		endcase
		case (fwdB)
			fwdMem: opB = memValue;
			fwdWb: opB = memWb.wbData;
			default: opB = idEx.srcData2;
		endcase
	end

	assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

	alu iAlu (
		.a(opA),
		.b(aluB),
		.op(idEx.ctrl.aluOp),
		.result(aluResult),
		.z(aluZ),
		.n(aluN),
		.v(aluV)
	);

	always_comb begin
		if (idEx.ctrl.llb) begin
			exResult = {opA[15:8], idEx.imm[7:0]}; // keep high byte of rd
		end else if (idEx.ctrl.lhb) begin
			exResult = {idEx.imm[7:0], opA[7:0]}; // keep low byte of rd
		end else begin
			exResult = aluResult;
		end
	end

	always_comb begin
		case (idEx.ctrl.cond)
			condNe: condMet = !zFlag;
			condEq: condMet = zFlag;
			condGt: condMet = !zFlag && !nFlag;
			condLt: condMet = nFlag;
			condGe: condMet = !nFlag;
			condLe: condMet = zFlag || nFlag;
			condOv: condMet = vFlag;
			default: condMet = 1'b1; // condAl
		endcase
	end

	assign branchTaken = idEx.valid & idEx.ctrl.branch & condMet;
	assign branchTarget = idEx.pcPlus2 + idEx.imm; // imm already scaled by two

	always_ff @(posedge clk) begin
		if (!rstN) begin
			zFlag <= 1'b0;
			nFlag <= 1'b0;
			vFlag <= 1'b0;
		end else if (pipeEn && idEx.valid) begin
			if (idEx.ctrl.setZ) begin
				zFlag <= aluZ;
			end
			if (idEx.ctrl.setNv) begin
				nFlag <= aluN;
				vFlag <= aluV;
			end
		end
	end

	assign exMemNext.valid = idEx.valid;
	assign exMemNext.memRead = idEx.ctrl.memRead;
	assign exMemNext.memWrite = idEx.ctrl.memWrite;
	assign exMemNext.regWrite = idEx.ctrl.regWrite;
	assign exMemNext.halt = idEx.ctrl.halt;
	assign exMemNext.result = exResult;
	assign exMemNext.storeData = opB; // forwarded rd of sw
	assign exMemNext.dst = idEx.dst;

	dataMemPort iDataPort (
		.clk(clk),
		.rstN(rstN),
		.access(exMem.valid & (exMem.memRead | exMem.memWrite)),
		.write(exMem.memWrite),
		.addr(exMem.result),
		.wdata(exMem.storeData),
		.rdata(portRdata),
		.busy(memBusy),
		.dmemReq(dmemReq),
		.dmemWrite(dmemWrite),
		.dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemAck(dmemAck),
		.dmemRdata(dmemRdata)
	);

	assign memValue = exMem.memRead ? portRdata : exMem.result;

	assign memWbNext.valid = exMem.valid;
	assign memWbNext.regWrite = exMem.regWrite;
	assign memWbNext.halt = exMem.halt;
	assign memWbNext.wbData = memValue;
	assign memWbNext.dst = exMem.dst;

	hazardUnit iHazard (
		.idSrc1(idSrc1),
		.idSrc2(idSrc2),
		.exSrc1(idEx.src1),
		.exSrc2(idEx.src2),
		.exDst(idEx.dst),
		.exMemRead(idEx.valid & idEx.ctrl.memRead),
		.memDst(exMem.dst),
		.memRegWrite(exMem.valid & exMem.regWrite),
		.wbDst(memWb.dst),
		.wbRegWrite(memWb.valid & memWb.regWrite),
		.branchTaken(branchTaken),
		.memBusy(memBusy),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stall(stall),
		.flush(flush),
		.pipeEn(pipeEn)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ifId <= '0;
			idEx <= '0;
			exMem <= '0;
			memWb <= '0;
		end else if (pipeEn) begin // whole core freezes on a pending access
			ifId <= ifIdNext;
			idEx <= idExNext;
			exMem <= exMemNext;
			memWb <= memWbNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			haltSeen <= 1'b0;
		end else if (memWb.valid && memWb.halt) begin
			haltSeen <= 1'b1;
		end
	end

	assign hlt = haltSeen | (memWb.valid & memWb.halt); // high from writeback on

endmodule

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;

	logic clk;
	logic rstN = 1'b0;
	word_t pc;
	word_t imemData;
	logic dmemReq, dmemWrite, hlt;
	word_t dmemAddr, dmemWdata;
	logic dmemAck = 1'b0;
	word_t dmemRdata = 16'h0000;

	word_t testWords [0:1023]; // raw contents of the tests file
	word_t imem [256];
	word_t dmem [256];
	word_t expAddr [64];
	word_t expData [64];
	int nStores = 0;
	int storeIdx = 0;   // stores seen in the current test
	int errors = 0;     // main flow
	int memErrors = 0;  // memory model
	int limitCycles = 0;
	bit limitReady = 1'b0;
	int ackCnt = 0;
	int relCnt = 0;
	logic reqSeen = 1'b0;

	cpu i_dut (
		.clk(clk),
		.rstN(rstN),
		.pc(pc),
		.imemData(imemData),
		.dmemReq(dmemReq),
		.dmemWrite(dmemWrite),
		.dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemAck(dmemAck),
		.dmemRdata(dmemRdata),
		.hlt(hlt)
	);

	assign imemData = imem[pc[8:1]]; // same-cycle instruction read

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic checkEq(input word_t got, input word_t exp, input string what,
			output int bad);
		bad = 0;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
			bad = 1;
		end
	endtask

	function automatic int wordAt(int p);
		return {16'd0, testWords[p]};
	endfunction

	// four-phase slave with random ack and release delays
	always @(posedge clk) begin
		int bad;
		if (!rstN) begin
			dmemAck <= 1'b0;
			reqSeen <= 1'b0;
			storeIdx = 0;
			ackCnt <= $urandom % 4;
		end else begin
			if (dmemReq && !reqSeen && dmemAck) begin
				$display("protocol error at %0t ns: req raised while ack is still high", $time);
				memErrors++;
			end
			reqSeen <= dmemReq;
			if (dmemReq && !dmemAck) begin
				if (ackCnt == 0) begin
					dmemAck <= 1'b1;
					relCnt <= $urandom % 4;
					if (dmemWrite) begin
						if (storeIdx >= nStores) begin
							$display("extra store at %0t ns: addr %h data %h", $time,
								dmemAddr, dmemWdata);
							memErrors++;
						end else begin
							checkEq(dmemAddr, expAddr[storeIdx], "store address", bad);
							memErrors += bad;
							checkEq(dmemWdata, expData[storeIdx], "store data", bad);
							memErrors += bad;
						end
						storeIdx = storeIdx + 1;
					end else begin
						dmemRdata <= dmem[dmemAddr[8:1]];
					end
				end else begin
					ackCnt <= ackCnt - 1;
				end
			end else if (!dmemReq && dmemAck) begin
				if (relCnt == 0) begin
					dmemAck <= 1'b0; // close the handshake
					ackCnt <= $urandom % 4;
				end else begin
					relCnt <= relCnt - 1;
				end
			end
		end
	end

	initial begin
		wait (limitReady);
		repeat (limitCycles) @(posedge clk);
		$display("watchdog timeout after %0d cycles, the core never finished", limitCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int nTests;
		int p;
		int n;
		int total;
		int bad;
		word_t haltAddr;
		word_t a;
		void'($urandom(19));
		$readmemh("verif/cpuTests.txt", testWords);
		nTests = wordAt(0);
		p = 1;
		total = 0;
		for (int t = 0; t < nTests; t++) begin // sizing pass for the watchdog
			n = wordAt(p);
			total += n;
			p += 1 + 2 * n;
			p += 1 + 2 * wordAt(p);
			p += 1 + 2 * wordAt(p);
			p += 1;
		end
		limitCycles = 60 * total;
		limitReady = 1'b1;
		p = 1;
		for (int t = 0; t < nTests; t++) begin
			@(posedge clk);
			rstN <= 1'b0;
			for (int i = 0; i < 256; i++) begin
				imem[i] = 16'hD000 | word_t'(i); // illegal opcode decodes as a no-op
				dmem[i] = 16'h5A00 ^ word_t'(i * 3);
			end
			n = wordAt(p);
			p++;
			for (int i = 0; i < n; i++) begin
				a = testWords[p];
				imem[a[8:1]] = testWords[p + 1];
				p += 2;
			end
			n = wordAt(p);
			p++;
			for (int i = 0; i < n; i++) begin
				a = testWords[p];
				dmem[a[8:1]] = testWords[p + 1];
				p += 2;
			end
			nStores = wordAt(p);
			p++;
			for (int i = 0; i < nStores; i++) begin
				expAddr[i] = testWords[p];
				expData[i] = testWords[p + 1];
				p += 2;
			end
			haltAddr = testWords[p];
			p++;
			repeat (3) begin
				@(posedge clk);
				checkEq({15'd0, dmemReq}, 16'd0, "dmemReq in reset", bad);
				errors += bad;
			end
			rstN <= 1'b1;
			@(posedge clk);
			while (!hlt) @(posedge clk);
			if (storeIdx < nStores) begin
				$display("test %0d: missing store, saw %0d of %0d", t, storeIdx, nStores);
				errors++;
			end
			repeat (5) begin // hlt sticks and fetch stays parked
				@(posedge clk);
				checkEq({15'd0, hlt}, 16'd1, "hlt held", bad);
				errors += bad;
				checkEq(pc, haltAddr + 16'd2, "pc after halt", bad);
				errors += bad;
			end
		end
		$display("done %0d tests, %0d errors", nTests, errors + memErrors);
		if (errors + memErrors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== verif/cpuTests.txt ====
// first word: test count; per test: nProg then addr instr pairs, nData then addr data
// pairs, nStores then addr data pairs in program order, then the hlt address
0003
// alu ops, saturation, mem and wb forwarding
0013
0000 A105 0002 A203 0004 0312 0006 1431 0008 2543
000A 4654 000C B780 000E 5873 0010 B97F 0012 0A99
0014 1B71 0016 9B06 0018 9300 001A 9401 001C 9502
001E 9603 0020 9804 0022 9A05 0024 F000
0000
0007
000C 8000 0000 0008 0002 0003 0004 000B
0006 00B0 0008 F000 000A 7FFF
0024
// load-use bubbles and byte loads
0010
0000 A120 0002 8210 0004 0322 0006 9312 0008 8411
000A 1542 000C 9513 000E 8610 0010 9614 0012 B6AB
0014 A6CD 0016 9615 0018 A799 001A B788 001C 9716
001E F000
0002
0020 1234 0022 FFFE
0005
0024 2468 0026 EDCA 0028 1234 002A ABCD 002C 8899
001E
// every condition taken and not taken, then a counted loop
0026
0000 A101 0002 A202 0004 1311 0006 C201 0008 9100
000A C001 000C 9201 000E 1412 0010 C601 0012 9100
0014 C801 0016 C401 0018 CA01 001A 9100 001C CC01
001E 1521 0020 C401 0022 9100 0024 C801 0026 9100
0028 B67F 002A 0766 002C CC01 002E 9100 0030 2811
0032 CC01 0034 9100 0036 C001 0038 9702 003A A903
003C AA10 003E 99A0 0040 0AA2 0042 1991 0044 C1FC
0046 CE01 0048 9100 004A F000
0000
0005
0002 0002 0004 7FFF 0010 0003 0012 0002 0014 0001
004A

// ==== sim.f ====
common/cpuPkg.sv
cpu/alu.sv
cpu/controlUnit.sv
cpu/registerFile.sv
cpu/hazardUnit.sv
rtl/dataMemPort.sv
cpu/cpu.sv
verif/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpuTb -f sim.f -o cpuSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/cpuSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
